//--- Makefile
TOP := fc_tb

.PHONY: lint sim clean

lint:
	verilator --lint-only --timing -Wno-fatal --top-module $(TOP) -f sources.f

sim:
	verilator --binary --timing --assert -Wno-fatal --top-module $(TOP) -f sources.f -o $(TOP)_sim
	./obj_dir/$(TOP)_sim | tee sim.log
	grep -q "STATUS: PASS" sim.log

clean:
	rm -rf obj_dir sim.log

//--- sim/fc_checker.sv
module fc_checker (
    input  logic                              clk,
    input  logic                              i_busy,
    input  logic                              i_result_valid,
    input  logic [fc_pkg::CLASS_W-1:0]        i_result_class,
    input  logic signed [fc_pkg::SCORE_W-1:0] i_result_score,
    output int                                o_done_cnt,
    output int                                o_fail_cnt
);
    timeunit 1ns;
    timeprecision 1ps;

    import fc_pkg::*;

    localparam int IDLE_TIMEOUT  = 20000;
    localparam int CLEAR_TIMEOUT = 8;
    localparam int RUN_TIMEOUT   = 2000;

    string                     exp_name;
    logic [CLASS_W-1:0]        exp_class;
    logic signed [SCORE_W-1:0] exp_score;
    bit                        armed = 1'b0;
    int                        pass_cnt;

    // Loaded by the testbench just before each start pulse
    task automatic expect_result(input string name, input logic [CLASS_W-1:0] cls,
                                 input logic signed [SCORE_W-1:0] score);
        exp_name  = name;
        exp_class = cls;
        exp_score = score;
        armed     = 1'b1;
    endtask

    task automatic print_summary();
        $display("Runs %0d, passed %0d, failed %0d", o_done_cnt, pass_cnt, o_fail_cnt);
    endtask

    //////////////////////////////////////////////////////////////////////
    // Result watcher sampling on the falling edge
    //////////////////////////////////////////////////////////////////////

    initial begin : watch
        int cycles;
        bit busy_seen;
        o_done_cnt = 0;
        o_fail_cnt = 0;
        pass_cnt   = 0;
        forever begin
            cycles = 0;
            while (!armed && cycles < IDLE_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (!armed) begin
                $display("No run was started within %0d cycles", IDLE_TIMEOUT);
                o_fail_cnt++;
                break;
            end
            armed = 1'b0;
            // Old result drops in the cycle after the start is taken
            cycles = 0;
            while (i_result_valid && cycles < CLEAR_TIMEOUT) begin
                @(negedge clk);
                cycles++;
            end
            if (i_result_valid) begin
                $display("Test %s: o_result_valid never cleared after the start", exp_name);
                o_fail_cnt++;
            end else begin
                busy_seen = 1'b0;
                cycles    = 0;
                while (!i_result_valid && cycles < RUN_TIMEOUT) begin
                    @(negedge clk);
                    if (i_busy) begin
                        busy_seen = 1'b1;
                    end
                    cycles++;
                end
                if (!i_result_valid) begin
                    $display("Test %s timed out waiting for o_result_valid", exp_name);
                    o_fail_cnt++;
                end else if (i_result_class !== exp_class || i_result_score !== exp_score) begin
                    $display("Mismatch at %0d ns: %s expected class %0d score %0d, %s",
                             $time, exp_name, exp_class, exp_score,
                             $sformatf("got class %0d score %0d",
                                       i_result_class, i_result_score));
                    o_fail_cnt++;
                end else if (i_busy) begin
                    $display("Test %s: o_busy was still high with the result valid", exp_name);
                    o_fail_cnt++;
                end else if (!busy_seen) begin
                    $display("Test %s: o_busy never went high during the run", exp_name);
                    o_fail_cnt++;
                end else begin
                    $display("Test %s passed with class %0d score %0d",
                             exp_name, i_result_class, i_result_score);
                    pass_cnt++;
                end
            end
            o_done_cnt++;
        end
    end

endmodule

//--- sim/fc_tb.sv
module fc_tb;
    timeunit 1ns;
    timeprecision 1ps;

    import fc_pkg::*;

    localparam int RUN_TIMEOUT = 3000;
    localparam int TOTAL_RUNS  = 10;
    localparam int WT_SET      = CLASSES * FM_WORDS;
    localparam int SMALL       = 16;

    logic                      clk;
    logic                      rst_n;
    logic                      i_wr_en;
    logic                      i_wr_sel;
    logic [WT_ADDR_W-1:0]      i_wr_addr;
    logic [WORD_W-1:0]         i_wr_data;
    logic                      i_start;
    logic [FM_ADDR_W-1:0]      i_fm_base_addr;
    logic [WT_ADDR_W-1:0]      i_wt_base_addr;
    logic                      o_busy;
    logic                      o_result_valid;
    logic [CLASS_W-1:0]        o_result_class;
    logic signed [SCORE_W-1:0] o_result_score;
    int                        done_cnt;
    int                        fail_cnt;
    bit                        hung = 1'b0;

    // Model copies of both memories and a per-class weight pattern
    logic [WORD_W-1:0] fm_img [2**FM_ADDR_W];
    logic [WORD_W-1:0] wt_img [2**WT_ADDR_W];
    logic [WORD_W-1:0] pattern [FM_WORDS];

    fc_top i_dut (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_wr_en        (i_wr_en),
        .i_wr_sel       (i_wr_sel),
        .i_wr_addr      (i_wr_addr),
        .i_wr_data      (i_wr_data),
        .i_start        (i_start),
        .i_fm_base_addr (i_fm_base_addr),
        .i_wt_base_addr (i_wt_base_addr),
        .o_busy         (o_busy),
        .o_result_valid (o_result_valid),
        .o_result_class (o_result_class),
        .o_result_score (o_result_score)
    );

    fc_checker u_checker (
        .clk            (clk),
        .i_busy         (o_busy),
        .i_result_valid (o_result_valid),
        .i_result_class (o_result_class),
        .i_result_score (o_result_score),
        .o_done_cnt     (done_cnt),
        .o_fail_cnt     (fail_cnt)
    );

    initial begin
        clk = 1'b0;
        forever #20 clk = ~clk;
    end

    //////////////////////////////////////////////////////////////////////
    // Reference model
    //////////////////////////////////////////////////////////////////////

    function automatic void compute_expected(input int fm_base, input int wt_base,
                                             output logic [CLASS_W-1:0] best_class,
                                             output logic signed [SCORE_W-1:0] best_score);
        int                sum;
        int                score;
        int                best;
        int                fm_lane;
        int                wt_lane;
        logic [WORD_W-1:0] fm_w;
        logic [WORD_W-1:0] wt_w;
        best       = 0;
        best_class = '0;
        for (int c = 0; c < CLASSES; c++) begin
            sum = 0;
            for (int w = 0; w < FM_WORDS; w++) begin
                fm_w = fm_img[fm_base + w];
                wt_w = wt_img[wt_base + c * FM_WORDS + w];
                for (int l = 0; l < LANES; l++) begin
                    fm_lane = int'($signed(fm_w[8*l +: 8]));
                    wt_lane = int'($signed(wt_w[8*l +: 8]));
                    sum += fm_lane * wt_lane;
                end
            end
            score = sum >>> SCORE_SHIFT;
            if (score > 127) begin
                score = 127;
            end else if (score < -128) begin
                score = -128;
            end
            // Strict compare keeps the lower class on a tie
            if (c == 0 || score > best) begin
                best       = score;
                best_class = CLASS_W'(c);
            end
        end
        best_score = SCORE_W'(best);
    endfunction

    // Eight small signed lanes in the range -mag to mag-1
    function automatic logic [WORD_W-1:0] rand_word(input int mag);
        logic [WORD_W-1:0] word;
        int                value;
        for (int l = 0; l < LANES; l++) begin
            value          = int'($urandom_range(2 * mag - 1)) - mag;
            word[8*l +: 8] = value[7:0];
        end
        return word;
    endfunction

    //////////////////////////////////////////////////////////////////////
    // Memory loading
    //////////////////////////////////////////////////////////////////////

    task automatic write_word(input logic sel, input int addr, input logic [WORD_W-1:0] data);
        @(negedge clk);
        i_wr_en   = 1'b1;
        i_wr_sel  = sel;
        i_wr_addr = WT_ADDR_W'(addr);
        i_wr_data = data;
        if (sel) begin
            wt_img[addr] = data;
        end else begin
            fm_img[addr] = data;
        end
    endtask

    task automatic load_image(input int base);
        for (int w = 0; w < FM_WORDS; w++) begin
            write_word(1'b0, base + w, rand_word(SMALL));
        end
    endtask

    task automatic load_weights(input int base);
        for (int i = 0; i < WT_SET; i++) begin
            write_word(1'b1, base + i, rand_word(SMALL));
        end
    endtask

    task automatic fill_pattern(input logic [WORD_W-1:0] word);
        for (int w = 0; w < FM_WORDS; w++) begin
            pattern[w] = word;
        end
    endtask

    task automatic write_pattern(input int base, input int first, input int last);
        for (int c = first; c <= last; c++) begin
            for (int w = 0; w < FM_WORDS; w++) begin
                write_word(1'b1, base + c * FM_WORDS + w, pattern[w]);
            end
        end
    endtask

    //////////////////////////////////////////////////////////////////////
    // One run with expectation, start pulse and wait for the checker
    //////////////////////////////////////////////////////////////////////

    task automatic run_case(input string name, input int fm_base, input int wt_base,
                            input bit extra_start);
        logic [CLASS_W-1:0]        exp_class;
        logic signed [SCORE_W-1:0] exp_score;
        int                        done_before;
        int                        cycles;
        if (hung) begin
            return;
        end
        compute_expected(fm_base, wt_base, exp_class, exp_score);
        u_checker.expect_result(name, exp_class, exp_score);
        done_before = done_cnt;
        @(negedge clk);
        i_wr_en        = 1'b0;
        i_start        = 1'b1;
        i_fm_base_addr = FM_ADDR_W'(fm_base);
        i_wt_base_addr = WT_ADDR_W'(wt_base);
        @(negedge clk);
        i_start = 1'b0;
        if (extra_start) begin
            // A mid-run start with the other bases is ignored
            repeat (10) @(negedge clk);
            i_start        = 1'b1;
            i_fm_base_addr = FM_ADDR_W'(FM_WORDS - fm_base);
            i_wt_base_addr = WT_ADDR_W'(WT_SET - wt_base);
            @(negedge clk);
            i_start = 1'b0;
        end
        cycles = 0;
        while (done_cnt == done_before && cycles < RUN_TIMEOUT) begin
            @(negedge clk);
            cycles++;
        end
        if (done_cnt == done_before) begin
            $display("Run %s did not complete within %0d cycles", name, RUN_TIMEOUT);
            hung = 1'b1;
        end
    endtask

    initial begin : stimulus
        int chosen;
        rst_n          = 1'b0;
        i_wr_en        = 1'b0;
        i_wr_sel       = 1'b0;
        i_wr_addr      = '0;
        i_wr_data      = '0;
        i_start        = 1'b0;
        i_fm_base_addr = '0;
        i_wt_base_addr = '0;
        void'($urandom(32'h64ea_fd00));
        repeat (4) @(negedge clk);
        rst_n = 1'b1;

        load_image(0);
        load_weights(0);
        run_case("random", 0, 0, 1'b0);

        // Same weights for every class
        for (int w = 0; w < FM_WORDS; w++) begin
            pattern[w] = rand_word(SMALL);
        end
        write_pattern(0, 0, CLASSES - 1);
        run_case("ties", 0, 0, 1'b0);

        // Max image with every class pinned low but one
        for (int w = 0; w < FM_WORDS; w++) begin
            write_word(1'b0, w, {LANES{8'h7f}});
        end
        fill_pattern({LANES{8'h80}});
        write_pattern(0, 0, CLASSES - 1);
        chosen = int'($urandom_range(CLASSES - 1, 1));
        fill_pattern({LANES{8'h7f}});
        write_pattern(0, chosen, chosen);
        run_case("sat_high", 0, 0, 1'b0);
        fill_pattern({LANES{8'h80}});
        write_pattern(0, chosen, chosen);
        run_case("sat_low", 0, 0, 1'b0);

        // Two images and two weight sets
        load_image(0);
        load_image(FM_WORDS);
        load_weights(0);
        load_weights(WT_SET);
        for (int f = 0; f < 2; f++) begin
            for (int g = 0; g < 2; g++) begin
                run_case($sformatf("base_fm%0d_wt%0d", f * FM_WORDS, g * WT_SET),
                         f * FM_WORDS, g * WT_SET, 1'b0);
            end
        end

        run_case("back_to_back_a", FM_WORDS, 0, 1'b1);
        run_case("back_to_back_b", 0, WT_SET, 1'b1);

        u_checker.print_summary();
        if (!hung && fail_cnt == 0 && done_cnt == TOTAL_RUNS) begin
            $display("STATUS: PASS");
        end else begin
            $display("STATUS: FAIL");
        end
        $finish;
    end

endmodule

//--- sources.f
src/fc_pkg.sv
src/fc_word_ram.sv
src/fc_dot_unit.sv
src/fc_classifier.sv
src/fc_top.sv
sim/fc_checker.sv
sim/fc_tb.sv

//--- src/fc_classifier.sv
module fc_classifier (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               i_start,
    input  logic [fc_pkg::FM_ADDR_W-1:0]       i_fm_base_addr,
    input  logic [fc_pkg::WT_ADDR_W-1:0]       i_wt_base_addr,
    output logic [fc_pkg::FM_ADDR_W-1:0]       o_fm_addr,
    output logic [fc_pkg::WT_ADDR_W-1:0]       o_wt_addr,
    output logic                               o_word_valid,
    output logic                               o_word_last,
    input  logic                               i_dot_valid,
    input  logic signed [fc_pkg::ACC_W-1:0]    i_dot_sum,
    output logic                               o_busy,
    output logic                               o_result_valid,
    output logic [fc_pkg::CLASS_W-1:0]         o_result_class,
    output logic signed [fc_pkg::SCORE_W-1:0]  o_result_score
);
    import fc_pkg::*;

    logic [STATE_W-1:0]        state;
    logic [WORD_IDX_W-1:0]     word_idx;
    logic [CLASS_W-1:0]        class_idx;
    logic [WT_ADDR_W-1:0]      class_off;
    logic [FM_ADDR_W-1:0]      fm_base_q;
    logic [WT_ADDR_W-1:0]      wt_base_q;
    logic [CLASS_W-1:0]        dot_cnt;
    logic                      start_ok;
    logic                      last_word;
    logic                      last_class;
    logic                      run_done;
    logic signed [ACC_W-1:0]   sum_shr;
    logic signed [SCORE_W-1:0] score_sat;
    logic                      take_best;

    assign start_ok   = i_start && (state == ST_IDLE);
    assign last_word  = (word_idx == WORD_IDX_W'(FM_WORDS - 1));
    assign last_class = (class_idx == CLASS_W'(CLASSES - 1));
    assign run_done   = i_dot_valid && (dot_cnt == CLASS_W'(CLASSES - 1));
    assign o_busy     = (state != ST_IDLE);

    //////////////////////////////////////////////////////////////////////
    // Run FSM and address generation
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            state     <= ST_IDLE;
            word_idx  <= '0;
            class_idx <= '0;
            class_off <= '0;
            fm_base_q <= '0;
            wt_base_q <= '0;
        end else begin
            case (state)
                ST_IDLE: begin
                    if (start_ok) begin
                        state     <= ST_ISSUE;
                        word_idx  <= '0;
                        class_idx <= '0;
                        class_off <= '0;
                        fm_base_q <= i_fm_base_addr;
                        wt_base_q <= i_wt_base_addr;
                    end
                end
                ST_ISSUE: begin
                    if (last_word) begin
                        word_idx <= '0;
                        if (last_class) begin
                            state <= ST_DRAIN;
                        end else begin
                            class_idx <= class_idx + 1'b1;
                            class_off <= class_off + WT_ADDR_W'(FM_WORDS);
                        end
                    end else begin
                        word_idx <= word_idx + 1'b1;
                    end
                end
                ST_DRAIN: begin
                    // Wait for the last class to leave the dot unit
                    if (run_done) begin
                        state <= ST_IDLE;
                    end
                end
                default: begin
                    state <= ST_IDLE;
                end
            endcase
        end
    end

    assign o_fm_addr = fm_base_q + FM_ADDR_W'(word_idx);
    assign o_wt_addr = wt_base_q + class_off + WT_ADDR_W'(word_idx);

    // Strobes delayed one cycle to meet the RAM read data
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            o_word_valid <= 1'b0;
            o_word_last  <= 1'b0;
        end else begin
            o_word_valid <= (state == ST_ISSUE);
            o_word_last  <= (state == ST_ISSUE) && last_word;
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Scaling, clamp and argmax
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        sum_shr = i_dot_sum >>> SCORE_SHIFT;
        if (sum_shr > SCORE_MAX) begin
            score_sat = SCORE_W'(SCORE_MAX);
        end else if (sum_shr < SCORE_MIN) begin
            score_sat = SCORE_W'(SCORE_MIN);
        end else begin
            score_sat = sum_shr[SCORE_W-1:0];
        end
    end

    // Strictly greater only, so ties keep the lower class
    assign take_best = (dot_cnt == '0) || (score_sat > o_result_score);

    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            dot_cnt        <= '0;
            o_result_valid <= 1'b0;
            o_result_class <= '0;
            o_result_score <= '0;
        end else begin
            if (start_ok) begin
                dot_cnt        <= '0;
                o_result_valid <= 1'b0;
            end else if (i_dot_valid) begin
                dot_cnt <= dot_cnt + 1'b1;
                if (run_done) begin
                    o_result_valid <= 1'b1;
                end
            end
            if (i_dot_valid && take_best) begin
                o_result_class <= dot_cnt;
                o_result_score <= score_sat;
            end
        end
    end

    // Dot sums only come back during a run
    a_no_dot_when_idle: assert property (
        @(posedge clk) disable iff (!rst_n) i_dot_valid |-> (state != ST_IDLE)
    );

    a_valid_not_busy: assert property (
        @(posedge clk) disable iff (!rst_n) !(o_result_valid && o_busy)
    );

endmodule

//--- src/fc_dot_unit.sv
module fc_dot_unit (
    input  logic                           clk,
    input  logic                           rst_n,
    input  logic                           i_word_valid,
    input  logic                           i_word_last,
    input  fc_pkg::fc_word_u               i_fm_word,
    input  fc_pkg::fc_word_u               i_wt_word,
    output logic                           o_dot_valid,
    output logic signed [fc_pkg::ACC_W-1:0] o_dot_sum
);
    import fc_pkg::*;

    logic signed [PROD_W-1:0] prod_q [LANES];
    logic signed [ACC_W-1:0]  sum4 [4];
    logic signed [ACC_W-1:0]  sum2 [2];
    logic signed [ACC_W-1:0]  tree_sum;
    logic signed [ACC_W-1:0]  tree_q;
    logic signed [ACC_W-1:0]  acc_q;
    logic                     v1_q;
    logic                     l1_q;
    logic                     v2_q;
    logic                     l2_q;
    logic                     acc_fresh;

    //////////////////////////////////////////////////////////////////////
    // Stage 1 computes eight signed lane products
    //////////////////////////////////////////////////////////////////////

    always_ff @(posedge clk) begin
        for (int i = 0; i < LANES; i++) begin
            prod_q[i] <= $signed(i_fm_word.lane[i]) * $signed(i_wt_word.lane[i]);
        end
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 2 sums the products in an adder tree
    //////////////////////////////////////////////////////////////////////

    always_comb begin
        for (int j = 0; j < 4; j++) begin
            sum4[j] = prod_q[2*j] + prod_q[2*j+1];
        end
        for (int k = 0; k < 2; k++) begin
            sum2[k] = sum4[2*k] + sum4[2*k+1];
        end
        tree_sum = sum2[0] + sum2[1];
    end

    always_ff @(posedge clk) begin
        tree_q <= tree_sum;
    end

    //////////////////////////////////////////////////////////////////////
    // Stage 3 accumulates per class
    //////////////////////////////////////////////////////////////////////

    // Restart from zero on the word after a class's last word
    always_ff @(posedge clk) begin
        if (v2_q) begin
            acc_q <= (acc_fresh ? '0 : acc_q) + tree_q;
        end
    end

    assign o_dot_sum = acc_q;

    // Valid and last follow the data down the pipe
    always_ff @(posedge clk or negedge rst_n) begin
        if (!rst_n) begin
            v1_q        <= 1'b0;
            l1_q        <= 1'b0;
            v2_q        <= 1'b0;
            l2_q        <= 1'b0;
            acc_fresh   <= 1'b1;
            o_dot_valid <= 1'b0;
        end else begin
            v1_q        <= i_word_valid;
            l1_q        <= i_word_last;
            v2_q        <= v1_q;
            l2_q        <= l1_q;
            o_dot_valid <= v2_q & l2_q;
            if (v2_q) begin
                acc_fresh <= l2_q;
            end
        end
    end

    // Last is only meaningful on a valid word
    a_last_has_valid: assert property (
        @(posedge clk) disable iff (!rst_n) i_word_last |-> i_word_valid
    );

endmodule

//--- src/fc_pkg.sv
package fc_pkg;

    //////////////////////////////////////////////////////////////////////
    // Data layout
    //////////////////////////////////////////////////////////////////////

    localparam int LANES      = 8;
    localparam int WORD_W     = 64;
    localparam int FM_WORDS   = 48;
    localparam int CLASSES    = 27;
    localparam int FM_ADDR_W  = 9;
    localparam int WT_ADDR_W  = 13;
    localparam int CLASS_W    = 5;
    localparam int WORD_IDX_W = 6;

    // Datapath widths
    localparam int PROD_W  = 16;
    localparam int ACC_W   = 24;
    localparam int SCORE_W = 8;

    // Score scaling and int8 clamp
    localparam int SCORE_SHIFT = 4;
    localparam int SCORE_MAX   = 127;
    localparam int SCORE_MIN   = -128;

    // Run controller states
    localparam int STATE_W = 2;
    localparam logic [STATE_W-1:0] ST_IDLE  = 2'd0;
    localparam logic [STATE_W-1:0] ST_ISSUE = 2'd1;
    localparam logic [STATE_W-1:0] ST_DRAIN = 2'd2;

    //////////////////////////////////////////////////////////////////////
    // One memory word, stored raw, decoded as eight int8 lanes
    //////////////////////////////////////////////////////////////////////

    // Lane 0 sits in the low byte
    typedef union packed {
        logic [WORD_W-1:0]           raw;
        logic [LANES-1:0][7:0]       lane;
    } fc_word_u;

endpackage

//--- src/fc_top.sv
module fc_top (
    input  logic                               clk,
    input  logic                               rst_n,
    input  logic                               i_wr_en,
    input  logic                               i_wr_sel,
    input  logic [fc_pkg::WT_ADDR_W-1:0]       i_wr_addr,
    input  logic [fc_pkg::WORD_W-1:0]          i_wr_data,
    input  logic                               i_start,
    input  logic [fc_pkg::FM_ADDR_W-1:0]       i_fm_base_addr,
    input  logic [fc_pkg::WT_ADDR_W-1:0]       i_wt_base_addr,
    output logic                               o_busy,
    output logic                               o_result_valid,
    output logic [fc_pkg::CLASS_W-1:0]         o_result_class,
    output logic signed [fc_pkg::SCORE_W-1:0]  o_result_score
);
    import fc_pkg::*;

    logic                    fm_wr_en;
    logic                    wt_wr_en;
    logic [FM_ADDR_W-1:0]    fm_addr;
    logic [WT_ADDR_W-1:0]    wt_addr;
    fc_word_u                fm_word;
    fc_word_u                wt_word;
    logic                    word_valid;
    logic                    word_last;
    logic                    dot_valid;
    logic signed [ACC_W-1:0] dot_sum;

    // Select 0 writes the feature map, 1 the weights
    assign fm_wr_en = i_wr_en & ~i_wr_sel;
    assign wt_wr_en = i_wr_en & i_wr_sel;

    fc_word_ram #(
        .DEPTH_W(FM_ADDR_W)
    ) u_fm_ram (
        .clk       (clk),
        .i_wr_en   (fm_wr_en),
        .i_wr_addr (i_wr_addr[FM_ADDR_W-1:0]),
        .i_wr_data (i_wr_data),
        .i_rd_addr (fm_addr),
        .o_rd_data (fm_word)
    );

    fc_word_ram #(
        .DEPTH_W(WT_ADDR_W)
    ) u_wt_ram (
        .clk       (clk),
        .i_wr_en   (wt_wr_en),
        .i_wr_addr (i_wr_addr),
        .i_wr_data (i_wr_data),
        .i_rd_addr (wt_addr),
        .o_rd_data (wt_word)
    );

    fc_classifier u_classifier (
        .clk            (clk),
        .rst_n          (rst_n),
        .i_start        (i_start),
        .i_fm_base_addr (i_fm_base_addr),
        .i_wt_base_addr (i_wt_base_addr),
        .o_fm_addr      (fm_addr),
        .o_wt_addr      (wt_addr),
        .o_word_valid   (word_valid),
        .o_word_last    (word_last),
        .i_dot_valid    (dot_valid),
        .i_dot_sum      (dot_sum),
        .o_busy         (o_busy),
        .o_result_valid (o_result_valid),
        .o_result_class (o_result_class),
        .o_result_score (o_result_score)
    );

    fc_dot_unit u_dot_unit (
        .clk          (clk),
        .rst_n        (rst_n),
        .i_word_valid (word_valid),
        .i_word_last  (word_last),
        .i_fm_word    (fm_word),
        .i_wt_word    (wt_word),
        .o_dot_valid  (dot_valid),
        .o_dot_sum    (dot_sum)
    );

endmodule

//--- src/fc_word_ram.sv
module fc_word_ram #(
    parameter int DEPTH_W = 9
) (
    input  logic                      clk,
    input  logic                      i_wr_en,
    input  logic [DEPTH_W-1:0]        i_wr_addr,
    input  logic [fc_pkg::WORD_W-1:0] i_wr_data,
    input  logic [DEPTH_W-1:0]        i_rd_addr,
    output fc_pkg::fc_word_u          o_rd_data
);
    import fc_pkg::*;

    logic [WORD_W-1:0] mem [2**DEPTH_W];

    // Write port, used only between runs
    always_ff @(posedge clk) begin
        if (i_wr_en) begin
            mem[i_wr_addr] <= i_wr_data;
        end
    end

    // Registered read, one cycle after the address
    always_ff @(posedge clk) begin
        o_rd_data.raw <= mem[i_rd_addr];
    end

endmodule
